// File: include/agc_cfg.svh
`ifndef AGC_CFG_SVH
`define AGC_CFG_SVH

// input samples, signed with 7 fraction bits
`define AGC_DIN_WIDTH 8

// power estimate, unsigned with 14 fraction bits
`define AGC_POW_WIDTH 16

// averaging window, power of two only
`define AGC_DELAY_LINE 32

// power results between two gain updates
`define AGC_REFRESH_SAMPLES 64

// fraction bits of the loop coefficient
`define AGC_ERROR_POINT 14

// gain format and limits, 1024 is unity
`define AGC_GAIN_WIDTH 12
`define AGC_GAIN_POINT 10
`define AGC_GAIN_RESET 1024
`define AGC_GAIN_LOW_LIM 256
`define AGC_GAIN_HIGH_LIM 3072

`endif

// File: logic/agc_pkg.sv
`default_nettype none

`include "agc_cfg.svh"

package agc_pkg;

    // signed sample, same format at input and output
    typedef logic signed [`AGC_DIN_WIDTH-1:0] sample_t;

    // unsigned power, squares keep all fraction bits
    typedef logic [`AGC_POW_WIDTH-1:0] power_t;

    // loop coefficient, unsigned
    typedef logic [`AGC_POW_WIDTH-1:0] coef_t;

    // unsigned gain with AGC_GAIN_POINT fraction bits
    typedef logic [`AGC_GAIN_WIDTH-1:0] gain_t;

    // stages of one least-squares update
    typedef enum logic [2:0] {
        IDLE,
        DIFF,
        MULT,
        ADD,
        CHECK
    } upd_state_t;

endpackage

`default_nettype wire

// File: logic/agc_ctrl_if.sv
`default_nettype none

interface agc_ctrl_if;

    // one-cycle stage strobes, fired in this order
    logic diff_en;
    logic mult_en;
    logic add_en;
    logic check_en;

    modport ctrl (
        output diff_en,
        output mult_en,
        output add_en,
        output check_en
    );

    modport dp (
        input diff_en,
        input mult_en,
        input add_en,
        input check_en
    );

endinterface

`default_nettype wire

// File: logic/avg_power.sv
`default_nettype none

`include "agc_cfg.svh"

module avg_power
    import agc_pkg::*;
(
    input  wire     clk,
    input  wire     rst,
    input  wire     sample_t din,
    input  wire     din_valid,
    output power_t  pow,
    output logic    pow_valid
);

    localparam int DL    = `AGC_DELAY_LINE;
    localparam int AW    = $clog2(DL);
    localparam int SUM_W = `AGC_POW_WIDTH + AW;

    // circular buffer of squared samples
    power_t mem [DL];
    logic [AW-1:0] wr_ptr;
    logic filled;

    logic signed [`AGC_POW_WIDTH-1:0] sq_s;
    power_t sq;
    power_t oldest;
    logic [SUM_W-1:0] sum_q;
    logic [SUM_W:0] sum_ext;

    // Q1.7 squared gives Q2.14, always non-negative and at most 16384
    assign sq_s = din * din;
    assign sq   = power_t'(sq_s);

    // before the first wrap the window still holds zeros
    assign oldest = filled ? mem[wr_ptr] : '0;

    assign sum_ext = {1'b0, sum_q} + (SUM_W+1)'(sq) - (SUM_W+1)'(oldest);

    always_ff @(posedge clk) begin
        if (din_valid) begin
            mem[wr_ptr] <= sq;
            pow         <= sum_ext[SUM_W-1:AW];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            filled    <= 1'b0;
            sum_q     <= '0;
            pow_valid <= 1'b0;
        end else begin
            pow_valid <= din_valid;
            if (din_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
                sum_q  <= sum_ext[SUM_W-1:0];
                if (wr_ptr == AW'(DL-1)) begin
                    filled <= 1'b1;
                end
            end
        end
    end

    // the value leaving the window was added earlier, so no borrow
    sum_no_underflow: assert property (
        @(posedge clk) disable iff (rst)
        din_valid |-> !sum_ext[SUM_W]
    );

endmodule

`default_nettype wire

// File: logic/refresh_timer.sv
`default_nettype none

`include "agc_cfg.svh"

module refresh_timer (
    input  wire  clk,
    input  wire  rst,
    input  wire  pow_valid,
    output logic refresh
);

    localparam int CW = $clog2(`AGC_REFRESH_SAMPLES);

    logic [CW-1:0] cnt;

    // modulo counter over power results
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt     <= '0;
            refresh <= 1'b0;
        end else begin
            refresh <= 1'b0;
            if (pow_valid) begin
                cnt <= cnt + 1'b1;
                // last result of the period
                if (cnt == CW'(`AGC_REFRESH_SAMPLES-1)) begin
                    refresh <= 1'b1;
                end
            end
        end
    end

    refresh_single_cycle: assert property (
        @(posedge clk) disable iff (rst)
        refresh |=> !refresh
    );

endmodule

`default_nettype wire

// File: logic/gain_update_fsm.sv
`default_nettype none

module gain_update_fsm
    import agc_pkg::*;
(
    input wire          clk,
    input wire          rst,
    input wire          refresh,
    agc_ctrl_if.ctrl    ctrl
);

    upd_state_t state_q;
    upd_state_t state_d;

    // one pass through the stages per refresh
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (refresh) begin
                    state_d = DIFF;
                end
            end
            DIFF: begin
                state_d = MULT;
            end
            MULT: begin
                state_d = ADD;
            end
            ADD: begin
                state_d = CHECK;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // strobes decoded straight from the state
    assign ctrl.diff_en  = (state_q == DIFF);
    assign ctrl.mult_en  = (state_q == MULT);
    assign ctrl.add_en   = (state_q == ADD);
    assign ctrl.check_en = (state_q == CHECK);

    // the refresh period must outlast one update pass
    refresh_only_in_idle: assert property (
        @(posedge clk) disable iff (rst)
        refresh |-> (state_q == IDLE)
    );

endmodule

`default_nettype wire

// File: logic/gain_datapath.sv
`default_nettype none

`include "agc_cfg.svh"

module gain_datapath
    import agc_pkg::*;
(
    input  wire     clk,
    input  wire     rst,
    input  wire     power_t pow,
    input  wire     power_t ref_pow,
    input  wire     coef_t error_coef,
    agc_ctrl_if.dp  dp,
    output gain_t   gain,
    output logic    gain_valid
);

    localparam int PW     = `AGC_POW_WIDTH;
    localparam int GW     = `AGC_GAIN_WIDTH;
    localparam int DIFF_W = PW + 1;
    localparam int PROD_W = 2 * DIFF_W;
    localparam int CAND_W = 16;
    // Q14 power times Q14 coefficient, brought down to the gain point
    localparam int SHIFT  = 2 * (`AGC_DIN_WIDTH - 1) + `AGC_ERROR_POINT - `AGC_GAIN_POINT;

    localparam logic signed [CAND_W-1:0] LOW_LIM  = `AGC_GAIN_LOW_LIM;
    localparam logic signed [CAND_W-1:0] HIGH_LIM = `AGC_GAIN_HIGH_LIM;

    logic signed [DIFF_W-1:0] diff_q;
    logic signed [PROD_W-1:0] prod_q;
    logic signed [PROD_W-1:0] prod_shift;
    logic signed [CAND_W-1:0] cand_d;
    logic signed [CAND_W-1:0] cand_q;
    logic cand_ok;
    gain_t gain_q;

    // arithmetic shift floors toward minus infinity
    assign prod_shift = prod_q >>> SHIFT;

    // the shifted step is below 2**14, so 16 bits never wrap
    assign cand_d = $signed({{(CAND_W-GW){1'b0}}, gain_q})
                  + $signed(prod_shift[CAND_W-1:0]);

    assign cand_ok = (cand_q >= LOW_LIM) && (cand_q <= HIGH_LIM);

    // stage registers
    always_ff @(posedge clk) begin
        if (dp.diff_en) begin
            // positive error means too little power, gain goes up
            diff_q <= $signed({1'b0, ref_pow}) - $signed({1'b0, pow});
        end
        if (dp.mult_en) begin
            prod_q <= diff_q * $signed({1'b0, error_coef});
        end
        if (dp.add_en) begin
            cand_q <= cand_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            gain_q     <= GW'(`AGC_GAIN_RESET);
            gain_valid <= 1'b0;
        end else begin
            gain_valid <= dp.check_en;
            // out-of-range candidates are dropped, old gain stays
            if (dp.check_en && cand_ok) begin
                gain_q <= cand_q[GW-1:0];
            end
        end
    end

    assign gain = gain_q;

    gain_in_limits: assert property (
        @(posedge clk) disable iff (rst)
        (gain_q >= GW'(`AGC_GAIN_LOW_LIM)) && (gain_q <= GW'(`AGC_GAIN_HIGH_LIM))
    );

endmodule

`default_nettype wire

// File: logic/gain_apply.sv
`default_nettype none

`include "agc_cfg.svh"

module gain_apply
    import agc_pkg::*;
(
    input  wire     clk,
    input  wire     rst,
    input  wire     sample_t din,
    input  wire     din_valid,
    input  wire     gain_t gain,
    output sample_t dout,
    output logic    dout_valid
);

    localparam int DW = `AGC_DIN_WIDTH;
    localparam int PW = DW + `AGC_GAIN_WIDTH + 1;

    localparam logic signed [PW-1:0] SAT_MAX = (2 ** (DW - 1)) - 1;
    localparam logic signed [PW-1:0] SAT_MIN = -(2 ** (DW - 1));

    logic signed [PW-1:0] prod;
    logic signed [PW-1:0] scaled;

    // gain is unsigned, so pad a zero sign bit
    assign prod   = din * $signed({1'b0, gain});
    assign scaled = prod >>> `AGC_GAIN_POINT;

    // clip to the sample range
    always_ff @(posedge clk) begin
        if (din_valid) begin
            if (scaled > SAT_MAX) begin
                dout <= SAT_MAX[DW-1:0];
            end else if (scaled < SAT_MIN) begin
                dout <= SAT_MIN[DW-1:0];
            end else begin
                dout <= scaled[DW-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= din_valid;
        end
    end

endmodule

`default_nettype wire

// File: logic/agc_top.sv
`default_nettype none

module agc_top
    import agc_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire sample_t din,
    input  wire          din_valid,
    input  wire power_t  ref_pow,
    input  wire coef_t   error_coef,
    output wire sample_t dout,
    output wire          dout_valid,
    output wire gain_t   gain,
    output wire          gain_valid
);

    power_t pow;
    logic   pow_valid;
    logic   refresh;

    agc_ctrl_if u_ctrl_if ();

    avg_power u_avg_power (
        .clk       (clk),
        .rst       (rst),
        .din       (din),
        .din_valid (din_valid),
        .pow       (pow),
        .pow_valid (pow_valid)
    );

    refresh_timer u_refresh_timer (
        .clk       (clk),
        .rst       (rst),
        .pow_valid (pow_valid),
        .refresh   (refresh)
    );

    gain_update_fsm u_gain_update_fsm (
        .clk     (clk),
        .rst     (rst),
        .refresh (refresh),
        .ctrl    (u_ctrl_if.ctrl)
    );

    gain_datapath u_gain_datapath (
        .clk        (clk),
        .rst        (rst),
        .pow        (pow),
        .ref_pow    (ref_pow),
        .error_coef (error_coef),
        .dp         (u_ctrl_if.dp),
        .gain       (gain),
        .gain_valid (gain_valid)
    );

    // the output path shares the loop gain
    gain_apply u_gain_apply (
        .clk        (clk),
        .rst        (rst),
        .din        (din),
        .din_valid  (din_valid),
        .gain       (gain),
        .dout       (dout),
        .dout_valid (dout_valid)
    );

endmodule

`default_nettype wire

// File: verif/agc_tb.sv
`default_nettype none

`include "agc_cfg.svh"

module agc_tb
    import agc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DL         = `AGC_DELAY_LINE;
    localparam int POW_POINT  = 2 * (`AGC_DIN_WIDTH - 1);
    localparam int STEP_SHIFT = POW_POINT + `AGC_ERROR_POINT - `AGC_GAIN_POINT;
    localparam int SAT_MAX    = (2 ** (`AGC_DIN_WIDTH - 1)) - 1;
    localparam int SAT_MIN    = -(2 ** (`AGC_DIN_WIDTH - 1));
    localparam int PERIOD_NS  = 8;

    logic    clk = 1'b0;
    logic    rst;
    sample_t din;
    logic    din_valid;
    power_t  ref_pow;
    coef_t   error_coef;
    sample_t dout;
    logic    dout_valid;
    gain_t   gain;
    logic    gain_valid;

    power_t case_ref[$];
    coef_t  case_coef[$];
    int     case_count[$];
    int     case_shift[$];

    logic [31:0] lfsr = 32'h5b82_4273;
    longint wd_limit = 0;
    int value_errors = 0;
    int pulse_errors = 0;
    int other_errors = 0;

    // reference model, one variable per register stage
    int      m_window [DL];
    int      m_wr;
    int      m_sum;
    int      m_pow;
    logic    m_pow_valid;
    int      m_count;
    logic    m_refresh;
    int      m_stage;
    longint  m_diff;
    longint  m_prod;
    longint  m_cand;
    gain_t   m_gain;
    logic    m_gain_valid;
    sample_t m_dout;
    logic    m_dout_valid;
    int      m_accepted;
    int      m_rejected;

    agc_top u_agc_top (
        .clk        (clk),
        .rst        (rst),
        .din        (din),
        .din_valid  (din_valid),
        .ref_pow    (ref_pow),
        .error_coef (error_coef),
        .dout       (dout),
        .dout_valid (dout_valid),
        .gain       (gain),
        .gain_valid (gain_valid)
    );

    always #(PERIOD_NS / 2) clk = ~clk;

    // galois form, taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end else begin
            return s >> 1;
        end
    endfunction

    task automatic draw_byte(output sample_t b);
        for (int k = 0; k < `AGC_DIN_WIDTH; k++) begin
            lfsr = lfsr_next(lfsr);
            b[k] = lfsr[0];
        end
    endtask

    task automatic load_cases(output bit ok);
        int fd;
        int n;
        int r;
        int c;
        int cnt;
        int sh;
        string line;
        ok = 1'b0;
        fd = $fopen("verif/agc_cases.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // lines starting with # hold column notes
                if (line.len() > 0 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%h %h %d %d", r, c, cnt, sh);
                    if (n == 4) begin
                        case_ref.push_back(power_t'(r));
                        case_coef.push_back(coef_t'(c));
                        case_count.push_back(cnt);
                        case_shift.push_back(sh);
                    end
                end
            end
            $fclose(fd);
            ok = (case_ref.size() > 0);
        end
    endtask

    task automatic reset_model();
        foreach (m_window[i]) begin
            m_window[i] = 0;
        end
        m_wr         = 0;
        m_sum        = 0;
        m_pow        = 0;
        m_pow_valid  = 1'b0;
        m_count      = 0;
        m_refresh    = 1'b0;
        m_stage      = 0;
        m_gain       = gain_t'(`AGC_GAIN_RESET);
        m_gain_valid = 1'b0;
        m_dout       = '0;
        m_dout_valid = 1'b0;
        m_accepted   = 0;
        m_rejected   = 0;
    endtask

    // one clock of the model, readers go before writers
    task automatic advance_model();
        int scaled;
        int sq;
        if (din_valid) begin
            scaled = (int'(din) * int'(m_gain)) >>> `AGC_GAIN_POINT;
            if (scaled > SAT_MAX) begin
                scaled = SAT_MAX;
            end else if (scaled < SAT_MIN) begin
                scaled = SAT_MIN;
            end
            m_dout = sample_t'(scaled);
        end
        m_dout_valid = din_valid;
        m_gain_valid = (m_stage == 4);
        case (m_stage)
            1: begin
                m_diff = longint'(ref_pow) - longint'(m_pow);
            end
            2: begin
                m_prod = m_diff * longint'(error_coef);
            end
            3: begin
                m_cand = longint'(m_gain) + (m_prod >>> STEP_SHIFT);
            end
            4: begin
                if (m_cand >= `AGC_GAIN_LOW_LIM && m_cand <= `AGC_GAIN_HIGH_LIM) begin
                    m_gain = gain_t'(m_cand);
                    m_accepted++;
                end else begin
                    m_rejected++;
                end
            end
            default: begin
            end
        endcase
        if (m_stage == 0) begin
            m_stage = m_refresh ? 1 : 0;
        end else begin
            m_stage = (m_stage + 1) % 5;
        end
        m_refresh = 1'b0;
        if (m_pow_valid) begin
            m_refresh = (m_count == `AGC_REFRESH_SAMPLES - 1);
            m_count   = (m_count + 1) % `AGC_REFRESH_SAMPLES;
        end
        if (din_valid) begin
            sq                = int'(din) * int'(din);
            m_sum             = m_sum + sq - m_window[m_wr];
            m_window[m_wr]    = sq;
            m_wr              = (m_wr + 1) % DL;
            m_pow             = m_sum / DL;
        end
        m_pow_valid = din_valid;
    endtask

    task automatic check_sample(input string name, input sample_t exp, input sample_t act);
        if (act !== exp) begin
            $display("Error: %s expected 0x%h, got 0x%h at %0t", name, exp, act, $time);
            value_errors++;
        end
    endtask

    task automatic check_gain(input string name, input gain_t exp, input gain_t act);
        if (act !== exp) begin
            $display("Error: %s expected 0x%h, got 0x%h at %0t", name, exp, act, $time);
            value_errors++;
        end
    endtask

    task automatic check_pulse(input string name, input logic exp, input logic act);
        if (exp === 1'b1 && act !== 1'b1) begin
            $display("The %s pulse is missing at %0t", name, $time);
            pulse_errors++;
        end else if (exp === 1'b0 && act !== 1'b0) begin
            $display("An unexpected %s pulse came at %0t", name, $time);
            pulse_errors++;
        end
    endtask

    task automatic verify_cycle();
        check_pulse("dout_valid", m_dout_valid, dout_valid);
        check_pulse("gain_valid", m_gain_valid, gain_valid);
        if (m_dout_valid && dout_valid) begin
            check_sample("dout", m_dout, dout);
        end
        check_gain("gain", m_gain, gain);
    endtask

    task automatic run_case(input int idx);
        int sent;
        sample_t b;
        rst        = 1'b1;
        din_valid  = 1'b0;
        din        = '0;
        ref_pow    = case_ref[idx];
        error_coef = case_coef[idx];
        repeat (4) @(negedge clk);
        rst = 1'b0;
        reset_model();
        sent = 0;
        // a sample every other cycle, then a drain past the last update
        for (int cyc = 0; cyc < 2 * case_count[idx] + 12; cyc++) begin
            verify_cycle();
            if (cyc % 2 == 0 && sent < case_count[idx]) begin
                draw_byte(b);
                din       = b >>> case_shift[idx];
                din_valid = 1'b1;
                sent++;
            end else begin
                din_valid = 1'b0;
            end
            advance_model();
            @(negedge clk);
        end
        $display("case %0d: %0d samples, %0d updates accepted, %0d rejected",
                 idx, sent, m_accepted, m_rejected);
    endtask

    initial begin
        bit ok;
        longint total;
        rst        = 1'b1;
        din        = '0;
        din_valid  = 1'b0;
        ref_pow    = '0;
        error_coef = '0;
        load_cases(ok);
        if (ok) begin
            total = 0;
            foreach (case_count[i]) begin
                total += case_count[i];
            end
            // two cycles per sample plus slack for resets and drains
            wd_limit = total * 2 * PERIOD_NS + 10_000;
            foreach (case_ref[i]) begin
                run_case(i);
            end
        end else begin
            $display("The case file could not be opened or holds no cases");
            other_errors++;
        end
        $display("value errors: %0d, pulse errors: %0d, other errors: %0d",
                 value_errors, pulse_errors, other_errors);
        if (value_errors + pulse_errors + other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        wait (wd_limit != 0);
        #(wd_limit);
        $display("The watchdog expired before the last case finished");
        $display("value errors: %0d, pulse errors: %0d, other errors: %0d",
                 value_errors, pulse_errors, other_errors + 1);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/agc_cases.txt
# ref_pow (hex, Q14)  error_coef (hex, Q14)  samples (decimal)  amplitude shift (decimal)
# no refresh yet, output path only
1000 0100 40 0
# low reference with a large coefficient, every step lands below the low limit
0000 ffff 256 0
# gain climbs until the high limit rejects the next step, full scale saturates
4000 2000 640 0
# large positive error, every step overshoots the high limit
ffff ffff 192 0
# moderate coefficient over a long run
0800 0400 1024 2
# gain walks down toward a low reference
0100 1000 512 1

// File: project.f
+incdir+include
logic/agc_pkg.sv
logic/agc_ctrl_if.sv
logic/avg_power.sv
logic/refresh_timer.sv
logic/gain_update_fsm.sv
logic/gain_datapath.sv
logic/gain_apply.sv
logic/agc_top.sv
verif/agc_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module agc_tb
out=$(./obj_dir/Vagc_tb)
echo "$out"
if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
